/* Makefile */
VERILATOR ?= verilator
TOP       ?= thread_sched_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/sched_cmd_pkg.sv */
package sched_cmd_pkg;
  import sched_thread_pkg::*;

  // response data width
  localparam int RSP_W = 16;

  typedef enum logic [1:0] {
    NOP  = 2'd0,
    RUN  = 2'd1,
    STOP = 2'd2,
    CFG  = 2'd3
  } cmd_op_e;

  typedef enum logic [1:0] {
    REG_ENABLE = 2'd0,
    REG_LIMIT  = 2'd1
  } reg_sel_e;

  typedef enum logic [1:0] {
    OK        = 2'd0,
    FULL      = 2'd1,
    NOT_FOUND = 2'd2,
    BAD_ARG   = 2'd3
  } rsp_code_e;

  // RUN and STOP view
  typedef struct packed {
    cmd_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [ARG_W-1:0]  arg;
  } cmd_thr_t;

  // CFG view, reserved bits are ignored
  typedef struct packed {
    cmd_op_e     op;
    reg_sel_e    sel;
    logic [11:0] rsvd;
    logic [15:0] value;
  } cmd_cfg_t;

  // opcode sits in the top two bits of both views
  typedef union packed {
    cmd_thr_t thr;
    cmd_cfg_t cfg;
  } cmd_word_u;

endpackage

/* design/sched_csr.sv */
`timescale 1ns/1ps

module sched_csr
  import sched_thread_pkg::*, sched_cmd_pkg::*;
#(
  parameter int MAX_THREADS = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cfg_we_i,
  input  reg_sel_e         cfg_sel_i,
  input  logic [15:0]      cfg_value_i,
  output rsp_code_e        cfg_code_o,
  output logic [RSP_W-1:0] cfg_old_o,
  output logic             dispatch_en_o,
  output logic [TID_W-1:0] thread_limit_o
);

  logic arg_ok;

  // old value and range check for the selected register
  always_comb begin
    arg_ok    = 1'b0;
    cfg_old_o = '0;
    case (cfg_sel_i)
      REG_ENABLE: begin
        cfg_old_o = RSP_W'(dispatch_en_o);
        arg_ok    = (cfg_value_i <= 16'd1);
      end
      REG_LIMIT: begin
        cfg_old_o = RSP_W'(thread_limit_o);
        arg_ok    = (cfg_value_i != '0) && (cfg_value_i <= MAX_THREADS);
      end
      default: begin
        arg_ok = 1'b0;
      end
    endcase
    cfg_code_o = arg_ok ? OK : BAD_ARG;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dispatch_en_o  <= 1'b1;
      thread_limit_o <= TID_W'(MAX_THREADS);
    end else if (cfg_we_i && arg_ok) begin
      if (cfg_sel_i == REG_ENABLE) begin
        dispatch_en_o <= cfg_value_i[0];
      end else begin
        thread_limit_o <= TID_W'(cfg_value_i);
      end
    end
  end

  // thread table sizes its tables by MAX_THREADS
  a_limit_range: assert property (@(posedge clk) disable iff (rst)
    (thread_limit_o != '0) && (thread_limit_o <= MAX_THREADS));

endmodule

/* design/sched_thread_pkg.sv */
package sched_thread_pkg;

  // thread entry address
  localparam int ADDR_W = 16;

  // argument passed to the thread on dispatch
  localparam int ARG_W = 14;

  // thread id, also used for the thread limit register
  localparam int TID_W = 16;

endpackage

/* design/thread_cmd_port.sv */
`timescale 1ns/1ps

module thread_cmd_port
  import sched_thread_pkg::*, sched_cmd_pkg::*;
#(
  parameter int CMD_DEPTH   = 4,
  parameter int RSP_CREDITS = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid_i,
  input  cmd_word_u         cmd_word_i,
  output logic              cmd_credit_o,
  output logic              rsp_valid_o,
  output rsp_code_e         rsp_code_o,
  output logic [RSP_W-1:0]  rsp_data_o,
  input  logic              rsp_credit_i,
  output logic              cfg_we_o,
  output reg_sel_e          cfg_sel_o,
  output logic [15:0]       cfg_value_o,
  input  rsp_code_e         cfg_code_i,
  input  logic [RSP_W-1:0]  cfg_old_i,
  output logic              tt_run_o,
  output logic              tt_stop_o,
  output logic [ADDR_W-1:0] tt_addr_o,
  output logic [ARG_W-1:0]  tt_arg_o,
  input  rsp_code_e         tt_code_i,
  input  logic [RSP_W-1:0]  tt_data_i
);

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);
  localparam int CRD_W = $clog2(RSP_CREDITS + 1);

  cmd_word_u        fifo_q [CMD_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] crd_q;
  cmd_word_u        head;
  logic             pop;
  rsp_code_e        rsp_code_d;
  logic [RSP_W-1:0] rsp_data_d;

  assign head = fifo_q[rd_ptr_q];

  // execute only when a response can be sent
  assign pop = (count_q != '0) && (crd_q != '0);

  // strobes to the owning block, valid in the pop cycle
  assign cfg_we_o    = pop && (head.cfg.op == CFG);
  assign cfg_sel_o   = head.cfg.sel;
  assign cfg_value_o = head.cfg.value;
  assign tt_run_o    = pop && (head.thr.op == RUN);
  assign tt_stop_o   = pop && (head.thr.op == STOP);
  assign tt_addr_o   = head.thr.addr;
  assign tt_arg_o    = head.thr.arg;

  always_comb begin
    case (head.thr.op)
      RUN, STOP: begin
        rsp_code_d = tt_code_i;
        rsp_data_d = tt_data_i;
      end
      CFG: begin
        rsp_code_d = cfg_code_i;
        rsp_data_d = cfg_old_i;
      end
      default: begin
        rsp_code_d = OK;
        rsp_data_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      crd_q        <= CRD_W'(RSP_CREDITS);
      cmd_credit_o <= 1'b0;
      rsp_valid_o  <= 1'b0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q      <= count_q + CNT_W'(cmd_valid_i) - CNT_W'(pop);
      crd_q        <= crd_q - CRD_W'(pop) + CRD_W'(rsp_credit_i);
      cmd_credit_o <= pop;
      rsp_valid_o  <= pop;
    end
  end

  // command storage and response payload
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      fifo_q[wr_ptr_q] <= cmd_word_i;
    end
    if (pop) begin
      rsp_code_o <= rsp_code_d;
      rsp_data_o <= rsp_data_d;
    end
  end

  // sender must hold a credit, so a push never finds the FIFO full
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    cmd_valid_i |-> (count_q != CNT_W'(CMD_DEPTH)));

  // consumer returns no more credits than it was given
  a_crd_bound: assert property (@(posedge clk) disable iff (rst)
    crd_q <= CRD_W'(RSP_CREDITS));

endmodule

/* design/thread_sched_top.sv */
`timescale 1ns/1ps

module thread_sched_top
  import sched_thread_pkg::*, sched_cmd_pkg::*;
#(
  parameter int MAX_THREADS = 8,
  parameter int CMD_DEPTH   = 4,
  parameter int RSP_CREDITS = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid_i,
  input  cmd_word_u         cmd_word_i,
  output logic              cmd_credit_o,
  output logic              rsp_valid_o,
  output rsp_code_e         rsp_code_o,
  output logic [RSP_W-1:0]  rsp_data_o,
  input  logic              rsp_credit_i,
  input  logic              sched_next_i,
  output logic              next_valid_o,
  output logic              next_idle_o,
  output logic [TID_W-1:0]  next_tid_o,
  output logic [ADDR_W-1:0] next_addr_o,
  output logic [ARG_W-1:0]  next_arg_o
);

  // command port to register block
  logic             cfg_we;
  reg_sel_e         cfg_sel;
  logic [15:0]      cfg_value;
  rsp_code_e        cfg_code;
  logic [RSP_W-1:0] cfg_old;

  // command port to thread table
  logic              tt_run;
  logic              tt_stop;
  logic [ADDR_W-1:0] tt_addr;
  logic [ARG_W-1:0]  tt_arg;
  rsp_code_e         tt_code;
  logic [RSP_W-1:0]  tt_data;

  // register block to thread table
  logic             dispatch_en;
  logic [TID_W-1:0] thread_limit;

  thread_cmd_port #(
    .CMD_DEPTH   (CMD_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
  ) u_cmd_port (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_word_i   (cmd_word_i),
    .cmd_credit_o (cmd_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_code_o   (rsp_code_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_credit_i (rsp_credit_i),
    .cfg_we_o     (cfg_we),
    .cfg_sel_o    (cfg_sel),
    .cfg_value_o  (cfg_value),
    .cfg_code_i   (cfg_code),
    .cfg_old_i    (cfg_old),
    .tt_run_o     (tt_run),
    .tt_stop_o    (tt_stop),
    .tt_addr_o    (tt_addr),
    .tt_arg_o     (tt_arg),
    .tt_code_i    (tt_code),
    .tt_data_i    (tt_data)
  );

  sched_csr #(
    .MAX_THREADS (MAX_THREADS)
  ) u_csr (
    .clk            (clk),
    .rst            (rst),
    .cfg_we_i       (cfg_we),
    .cfg_sel_i      (cfg_sel),
    .cfg_value_i    (cfg_value),
    .cfg_code_o     (cfg_code),
    .cfg_old_o      (cfg_old),
    .dispatch_en_o  (dispatch_en),
    .thread_limit_o (thread_limit)
  );

  thread_table #(
    .MAX_THREADS (MAX_THREADS)
  ) u_table (
    .clk            (clk),
    .rst            (rst),
    .tt_run_i       (tt_run),
    .tt_stop_i      (tt_stop),
    .tt_addr_i      (tt_addr),
    .tt_arg_i       (tt_arg),
    .tt_code_o      (tt_code),
    .tt_data_o      (tt_data),
    .dispatch_en_i  (dispatch_en),
    .thread_limit_i (thread_limit),
    .sched_next_i   (sched_next_i),
    .next_valid_o   (next_valid_o),
    .next_idle_o    (next_idle_o),
    .next_tid_o     (next_tid_o),
    .next_addr_o    (next_addr_o),
    .next_arg_o     (next_arg_o)
  );

endmodule

/* design/thread_table.sv */
`timescale 1ns/1ps

module thread_table
  import sched_thread_pkg::*, sched_cmd_pkg::*;
#(
  parameter int MAX_THREADS = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              tt_run_i,
  input  logic              tt_stop_i,
  input  logic [ADDR_W-1:0] tt_addr_i,
  input  logic [ARG_W-1:0]  tt_arg_i,
  output rsp_code_e         tt_code_o,
  output logic [RSP_W-1:0]  tt_data_o,
  input  logic              dispatch_en_i,
  input  logic [TID_W-1:0]  thread_limit_i,
  input  logic              sched_next_i,
  output logic              next_valid_o,
  output logic              next_idle_o,
  output logic [TID_W-1:0]  next_tid_o,
  output logic [ADDR_W-1:0] next_addr_o,
  output logic [ARG_W-1:0]  next_arg_o
);

  localparam int IDX_W = (MAX_THREADS > 1) ? $clog2(MAX_THREADS) : 1;
  localparam int CNT_W = $clog2(MAX_THREADS + 1);

  // pending FIFO, oldest entry at pend_rd_q
  logic [ADDR_W-1:0] pend_addr_q [MAX_THREADS];
  logic [ARG_W-1:0]  pend_arg_q  [MAX_THREADS];
  logic [TID_W-1:0]  pend_tid_q  [MAX_THREADS];
  logic [IDX_W-1:0]  pend_rd_q;
  logic [IDX_W-1:0]  pend_wr_q;
  logic [CNT_W-1:0]  pend_cnt_q;

  // active slots
  logic [MAX_THREADS-1:0] slot_vld_q;
  logic [ADDR_W-1:0]      slot_addr_q [MAX_THREADS];
  logic [ARG_W-1:0]       slot_arg_q  [MAX_THREADS];
  logic [TID_W-1:0]       slot_tid_q  [MAX_THREADS];
  logic [CNT_W-1:0]       act_cnt_q;

  logic [TID_W-1:0] tid_q;
  logic [IDX_W-1:0] last_q;

  // round-robin scan state
  logic             scan_q;
  logic [IDX_W-1:0] scan_idx_q;
  logic [CNT_W-1:0] scan_steps_q;

  logic [MAX_THREADS-1:0] stop_hit;
  logic [CNT_W-1:0]       stop_cnt;
  logic [IDX_W-1:0]       free_idx;
  logic [CNT_W:0]         live_cnt;
  logic                   run_ok;
  logic                   run_accept;
  logic                   req_start;
  logic                   idle_now;
  logic                   promote;
  logic                   scan_act;
  logic [IDX_W-1:0]       cursor;
  logic                   cursor_hit;
  logic [CNT_W-1:0]       steps_done;
  logic                   scan_hit;
  logic                   scan_give_up;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(MAX_THREADS - 1)) ? '0 : idx + 1'b1;
  endfunction

  // stop match on all slots at once, and lowest free slot
  always_comb begin
    stop_hit = '0;
    stop_cnt = '0;
    free_idx = '0;
    for (int i = MAX_THREADS - 1; i >= 0; i--) begin
      if (!slot_vld_q[i]) begin
        free_idx = IDX_W'(i);
      end
    end
    for (int i = 0; i < MAX_THREADS; i++) begin
      stop_hit[i] = tt_stop_i && slot_vld_q[i] && (slot_addr_q[i] == tt_addr_i);
      stop_cnt    = stop_cnt + CNT_W'(stop_hit[i]);
    end
  end

  // admission counts pending plus active
  assign live_cnt   = pend_cnt_q + act_cnt_q;
  assign run_ok     = live_cnt < thread_limit_i;
  assign run_accept = tt_run_i && run_ok;

  always_comb begin
    if (tt_stop_i) begin
      tt_code_o = (stop_cnt != '0) ? OK : NOT_FOUND;
      tt_data_o = RSP_W'(stop_cnt);
    end else if (run_ok) begin
      tt_code_o = OK;
      tt_data_o = RSP_W'(tid_q);
    end else begin
      tt_code_o = FULL;
      tt_data_o = '0;
    end
  end

  // requests are taken only while no scan is in flight
  assign req_start = sched_next_i && !scan_q;
  assign idle_now  = req_start &&
                     (!dispatch_en_i || ((pend_cnt_q == '0) && (act_cnt_q == '0)));
  assign promote   = req_start && dispatch_en_i && (pend_cnt_q != '0);
  assign scan_act  = scan_q ||
                     (req_start && dispatch_en_i && (pend_cnt_q == '0) && (act_cnt_q != '0));

  // first probe happens in the request cycle itself
  assign cursor     = scan_q ? scan_idx_q : next_idx(last_q);
  assign cursor_hit = slot_vld_q[cursor] && !stop_hit[cursor];
  assign steps_done = scan_q ? scan_steps_q : '0;
  assign scan_hit   = scan_act && cursor_hit;

  // all slots may be stopped mid-scan, so give up after one full lap
  assign scan_give_up = scan_act && !cursor_hit &&
                        (steps_done == CNT_W'(MAX_THREADS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_rd_q    <= '0;
      pend_wr_q    <= '0;
      pend_cnt_q   <= '0;
      slot_vld_q   <= '0;
      act_cnt_q    <= '0;
      tid_q        <= TID_W'(1);
      last_q       <= IDX_W'(MAX_THREADS - 1);
      scan_q       <= 1'b0;
      scan_idx_q   <= '0;
      scan_steps_q <= '0;
      next_valid_o <= 1'b0;
      next_idle_o  <= 1'b0;
    end else begin
      next_valid_o <= promote || scan_hit;
      next_idle_o  <= idle_now || scan_give_up;
      if (run_accept) begin
        pend_wr_q <= next_idx(pend_wr_q);
        tid_q     <= tid_q + 1'b1;
      end
      if (promote) begin
        pend_rd_q <= next_idx(pend_rd_q);
      end
      pend_cnt_q <= pend_cnt_q + CNT_W'(run_accept) - CNT_W'(promote);
      slot_vld_q <= slot_vld_q & ~stop_hit;
      if (promote) begin
        slot_vld_q[free_idx] <= 1'b1;
      end
      act_cnt_q <= act_cnt_q - stop_cnt + CNT_W'(promote);
      if (promote) begin
        last_q <= free_idx;
      end else if (scan_hit) begin
        last_q <= cursor;
      end
      if (scan_hit || scan_give_up) begin
        scan_q <= 1'b0;
      end else if (scan_act) begin
        scan_q       <= 1'b1;
        scan_idx_q   <= next_idx(cursor);
        scan_steps_q <= steps_done + 1'b1;
      end
    end
  end

  // thread payload and dispatch outputs
  always_ff @(posedge clk) begin
    if (run_accept) begin
      pend_addr_q[pend_wr_q] <= tt_addr_i;
      pend_arg_q[pend_wr_q]  <= tt_arg_i;
      pend_tid_q[pend_wr_q]  <= tid_q;
    end
    if (promote) begin
      slot_addr_q[free_idx] <= pend_addr_q[pend_rd_q];
      slot_arg_q[free_idx]  <= pend_arg_q[pend_rd_q];
      slot_tid_q[free_idx]  <= pend_tid_q[pend_rd_q];
      next_tid_o            <= pend_tid_q[pend_rd_q];
      next_addr_o           <= pend_addr_q[pend_rd_q];
      next_arg_o            <= pend_arg_q[pend_rd_q];
    end else if (scan_hit) begin
      next_tid_o  <= slot_tid_q[cursor];
      next_addr_o <= slot_addr_q[cursor];
      next_arg_o  <= slot_arg_q[cursor];
    end
  end

  // one answer per request
  a_one_answer: assert property (@(posedge clk) disable iff (rst)
    !(next_valid_o && next_idle_o));

  // counter must track stops and promotions exactly
  a_occupancy: assert property (@(posedge clk) disable iff (rst)
    act_cnt_q == CNT_W'($countones(slot_vld_q)));

endmodule

/* sources.f */
+incdir+verif
design/sched_thread_pkg.sv
design/sched_cmd_pkg.sv
design/thread_cmd_port.sv
design/sched_csr.sv
design/thread_table.sv
design/thread_sched_top.sv
verif/thread_sched_tb.sv

/* verif/thread_sched_model.svh */
`ifndef THREAD_SCHED_MODEL_SVH
`define THREAD_SCHED_MODEL_SVH

typedef struct packed {
  logic [TID_W-1:0]  tid;
  logic [ADDR_W-1:0] addr;
  logic [ARG_W-1:0]  arg;
} thr_rec_t;

typedef struct packed {
  rsp_code_e        code;
  logic [RSP_W-1:0] data;
} rsp_rec_t;

// reference state: pending FIFO, active slots, registers
thr_rec_t         m_pend[$];
thr_rec_t         m_slot[MAX_THREADS];
bit               m_vld[MAX_THREADS];
int               m_last;
logic [TID_W-1:0] m_next_tid;
bit               m_en;
int               m_limit;

function automatic void model_reset();
  m_pend.delete();
  foreach (m_vld[i]) begin
    m_vld[i] = 1'b0;
  end
  m_last     = MAX_THREADS - 1;
  m_next_tid = TID_W'(1);
  m_en       = 1'b1;
  m_limit    = MAX_THREADS;
endfunction

// pending plus active, as the limit counts them
function automatic int live_threads();
  int n;
  n = m_pend.size();
  foreach (m_vld[i]) begin
    if (m_vld[i]) begin
      n++;
    end
  end
  return n;
endfunction

function automatic rsp_rec_t model_cmd(input cmd_word_u w);
  rsp_rec_t r;
  thr_rec_t t;
  int       n;
  r.code = OK;
  r.data = '0;
  n      = 0;
  case (w.thr.op)
    RUN: begin
      if (live_threads() < m_limit) begin
        t.tid  = m_next_tid;
        t.addr = w.thr.addr;
        t.arg  = w.thr.arg;
        m_pend.push_back(t);
        r.data     = RSP_W'(m_next_tid);
        m_next_tid = m_next_tid + 1'b1;
      end else begin
        r.code = FULL;
      end
    end
    STOP: begin
      // only active slots are searched
      foreach (m_vld[i]) begin
        if (m_vld[i] && (m_slot[i].addr == w.thr.addr)) begin
          m_vld[i] = 1'b0;
          n++;
        end
      end
      r.code = (n > 0) ? OK : NOT_FOUND;
      r.data = RSP_W'(n);
    end
    CFG: begin
      if (w.cfg.sel == REG_ENABLE) begin
        r.data = RSP_W'(m_en);
        if (w.cfg.value > 16'd1) begin
          r.code = BAD_ARG;
        end else begin
          m_en = w.cfg.value[0];
        end
      end else begin
        r.data = RSP_W'(m_limit);
        if ((w.cfg.value == 16'd0) || (int'(w.cfg.value) > MAX_THREADS)) begin
          r.code = BAD_ARG;
        end else begin
          m_limit = int'(w.cfg.value);
        end
      end
    end
    default: begin
      r.code = OK;
    end
  endcase
  return r;
endfunction

function automatic void model_next(output bit idle, output thr_rec_t t);
  int free_slot;
  int i;
  idle      = 1'b1;
  t         = '0;
  free_slot = -1;
  if (!m_en) begin
    return;
  end
  if (m_pend.size() != 0) begin
    // oldest pending goes to the lowest free slot
    for (int k = 0; k < MAX_THREADS; k++) begin
      if ((free_slot < 0) && !m_vld[k]) begin
        free_slot = k;
      end
    end
    t                 = m_pend.pop_front();
    m_slot[free_slot] = t;
    m_vld[free_slot]  = 1'b1;
    m_last            = free_slot;
    idle              = 1'b0;
  end else begin
    for (int k = 1; k <= MAX_THREADS; k++) begin
      i = (m_last + k) % MAX_THREADS;
      if (idle && m_vld[i]) begin
        t      = m_slot[i];
        m_last = i;
        idle   = 1'b0;
      end
    end
  end
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

task automatic check_rsp(input rsp_code_e got_code, input logic [RSP_W-1:0] got_data,
                         input rsp_rec_t exp);
  if (got_code !== exp.code) begin
    $display("** Error: rsp_code_o is %h, expected %h", got_code, exp.code);
    err_cnt++;
  end
  if (got_data !== exp.data) begin
    $display("** Error: rsp_data_o is %h, expected %h", got_data, exp.data);
    err_cnt++;
  end
endtask

task automatic check_thread(input logic [TID_W-1:0] tid, input logic [ADDR_W-1:0] addr,
                            input logic [ARG_W-1:0] arg, input thr_rec_t exp);
  if (tid !== exp.tid) begin
    $display("** Error: next_tid_o is %h, expected %h", tid, exp.tid);
    err_cnt++;
  end
  if (addr !== exp.addr) begin
    $display("** Error: next_addr_o is %h, expected %h", addr, exp.addr);
    err_cnt++;
  end
  if (arg !== exp.arg) begin
    $display("** Error: next_arg_o is %h, expected %h", arg, exp.arg);
    err_cnt++;
  end
endtask

`endif

/* verif/thread_sched_tb.sv */
`timescale 1ns/1ps

module thread_sched_tb
  import sched_thread_pkg::*, sched_cmd_pkg::*;
();

  // same values as the defaults of thread_sched_top
  localparam int MAX_THREADS = 8;
  localparam int CMD_DEPTH   = 4;
  localparam int RSP_CREDITS = 2;

  // entry kinds
  localparam int K_NEXT  = 0;
  localparam int K_CMD   = 1;
  localparam int K_POST  = 2;
  localparam int K_DRAIN = 3;

  logic              clk;
  logic              rst;
  logic              cmd_valid_i;
  cmd_word_u         cmd_word_i;
  logic              cmd_credit_o;
  logic              rsp_valid_o;
  rsp_code_e         rsp_code_o;
  logic [RSP_W-1:0]  rsp_data_o;
  logic              rsp_credit_i;
  logic              sched_next_i;
  logic              next_valid_o;
  logic              next_idle_o;
  logic [TID_W-1:0]  next_tid_o;
  logic [ADDR_W-1:0] next_addr_o;
  logic [ARG_W-1:0]  next_arg_o;

  int err_cnt;

  `include "thread_sched_model.svh"

  // stimulus table and expected values
  int        tab_kind[$];
  cmd_word_u tab_word[$];
  rsp_rec_t  tab_rsp[$];
  bit        tab_idle[$];
  thr_rec_t  tab_thr[$];

  rsp_rec_t    exp_q[$];
  int          crd_delay_q[$];
  logic [31:0] rng_state;
  bit          hold;
  int          cmd_credits;
  int          hold_crd_seen;
  int          posted;
  int          burst_err_base;
  bit          next_wait;
  bit          got_next;
  bit          got_idle;
  thr_rec_t    got_thr;
  int          tests;
  int          failed;
  int          cycle_cnt;
  int          timeout_limit;

  thread_sched_top uut (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_word_i   (cmd_word_i),
    .cmd_credit_o (cmd_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_code_o   (rsp_code_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_credit_i (rsp_credit_i),
    .sched_next_i (sched_next_i),
    .next_valid_o (next_valid_o),
    .next_idle_o  (next_idle_o),
    .next_tid_o   (next_tid_o),
    .next_addr_o  (next_addr_o),
    .next_arg_o   (next_arg_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout: no answer from the DUT after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic cmd_word_u thr_word(input cmd_op_e op, input logic [ADDR_W-1:0] addr,
                                         input logic [ARG_W-1:0] arg);
    cmd_word_u w;
    w.thr.op   = op;
    w.thr.addr = addr;
    w.thr.arg  = arg;
    return w;
  endfunction

  function automatic cmd_word_u cfg_word(input reg_sel_e sel, input logic [15:0] value);
    cmd_word_u w;
    w.cfg.op    = CFG;
    w.cfg.sel   = sel;
    w.cfg.rsvd  = '0;
    w.cfg.value = value;
    return w;
  endfunction

  // expected values are taken from the model as the table is built
  function automatic void add_entry(input int kind, input cmd_word_u word);
    rsp_rec_t r;
    thr_rec_t t;
    bit       idle;
    r    = '0;
    t    = '0;
    idle = 1'b0;
    if ((kind == K_CMD) || (kind == K_POST)) begin
      r = model_cmd(word);
    end else if (kind == K_NEXT) begin
      model_next(idle, t);
    end
    tab_kind.push_back(kind);
    tab_word.push_back(word);
    tab_rsp.push_back(r);
    tab_idle.push_back(idle);
    tab_thr.push_back(t);
  endfunction

  function automatic void build_table();
    model_reset();
    add_entry(K_NEXT, '0);
    add_entry(K_CMD, thr_word(RUN, 16'h1000, 14'h0011));
    add_entry(K_CMD, thr_word(RUN, 16'h2000, 14'h0022));
    add_entry(K_CMD, thr_word(RUN, 16'h3000, 14'h0033));
    // three promotions, then round robin over the slots
    for (int k = 0; k < 7; k++) begin
      add_entry(K_NEXT, '0);
    end
    add_entry(K_CMD, thr_word(STOP, 16'h2000, '0));
    add_entry(K_NEXT, '0);
    add_entry(K_NEXT, '0);
    add_entry(K_CMD, thr_word(STOP, 16'h7777, '0));
    add_entry(K_CMD, cfg_word(REG_LIMIT, 16'd3));
    add_entry(K_CMD, thr_word(RUN, 16'h4000, 14'h0044));
    add_entry(K_CMD, thr_word(RUN, 16'h5000, 14'h0055));
    add_entry(K_NEXT, '0);
    add_entry(K_CMD, cfg_word(REG_LIMIT, 16'd0));
    add_entry(K_CMD, cfg_word(REG_LIMIT, 16'd3));
    add_entry(K_CMD, cfg_word(REG_ENABLE, 16'd0));
    add_entry(K_NEXT, '0);
    add_entry(K_CMD, cfg_word(REG_ENABLE, 16'd2));
    add_entry(K_CMD, cfg_word(REG_ENABLE, 16'd1));
    for (int k = 0; k < 3; k++) begin
      add_entry(K_NEXT, '0);
    end
    add_entry(K_CMD, cfg_word(REG_LIMIT, 16'd8));
    // burst sent while response credits are held back
    add_entry(K_POST, thr_word(RUN, 16'h6000, 14'h0066));
    add_entry(K_POST, thr_word(RUN, 16'h7000, 14'h0077));
    add_entry(K_POST, thr_word(NOP, '0, '0));
    add_entry(K_POST, thr_word(STOP, 16'h1000, '0));
    add_entry(K_DRAIN, '0);
    add_entry(K_NEXT, '0);
    add_entry(K_NEXT, '0);
  endfunction

  // sample outputs at the falling edge, then return credits
  task automatic step_cycle();
    rsp_rec_t exp;
    @(negedge clk);
    cmd_valid_i  = 1'b0;
    sched_next_i = 1'b0;
    rsp_credit_i = 1'b0;
    if (cmd_credit_o) begin
      cmd_credits++;
      hold_crd_seen++;
      if (cmd_credits > CMD_DEPTH) begin
        $display("more command credits came back than commands were sent");
        err_cnt++;
      end
    end
    if (rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("response arrived with no command outstanding");
        err_cnt++;
      end else begin
        exp = exp_q.pop_front();
        check_rsp(rsp_code_o, rsp_data_o, exp);
      end
      rng_state = xorshift(rng_state);
      crd_delay_q.push_back(int'(rng_state[1:0]));
    end
    if (next_valid_o || next_idle_o) begin
      if (!next_wait || got_next) begin
        $display("dispatch answer without a request");
        err_cnt++;
      end
      got_next = 1'b1;
      got_idle = next_idle_o;
      got_thr  = {next_tid_o, next_addr_o, next_arg_o};
    end
    if (!hold && (crd_delay_q.size() != 0) && (crd_delay_q[0] == 0)) begin
      crd_delay_q.delete(0);
      rsp_credit_i = 1'b1;
    end
    foreach (crd_delay_q[k]) begin
      if (crd_delay_q[k] > 0) begin
        crd_delay_q[k]--;
      end
    end
  endtask

  task automatic send_cmd(input int i);
    while (cmd_credits == 0) begin
      step_cycle();
    end
    cmd_valid_i = 1'b1;
    cmd_word_i  = tab_word[i];
    cmd_credits--;
    exp_q.push_back(tab_rsp[i]);
    step_cycle();
  endtask

  task automatic wait_rsp_drain();
    while (exp_q.size() != 0) begin
      step_cycle();
    end
  endtask

  task automatic do_dispatch(input int i);
    sched_next_i = 1'b1;
    next_wait    = 1'b1;
    got_next     = 1'b0;
    step_cycle();
    while (!got_next) begin
      step_cycle();
    end
    next_wait = 1'b0;
    if (got_idle != tab_idle[i]) begin
      $display("** Error: next_idle_o is %h, expected %h", got_idle, tab_idle[i]);
      err_cnt++;
    end else if (!got_idle) begin
      check_thread(got_thr.tid, got_thr.addr, got_thr.arg, tab_thr[i]);
    end
  endtask

  // all earlier credits are back, so the port starts with its full count
  task automatic start_hold();
    if (!hold) begin
      while (crd_delay_q.size() != 0) begin
        step_cycle();
      end
      hold           = 1'b1;
      hold_crd_seen  = 0;
      posted         = 0;
      burst_err_base = err_cnt;
    end
  endtask

  task automatic finish_burst();
    int early;
    early = (posted < RSP_CREDITS) ? posted : RSP_CREDITS;
    while ((posted - exp_q.size()) < early) begin
      step_cycle();
    end
    // nothing more may move while credits stay withheld
    repeat (CMD_DEPTH) begin
      step_cycle();
    end
    if (hold_crd_seen != early) begin
      $display("burst: %0d command credits came back while held, expected %0d",
               hold_crd_seen, early);
      err_cnt++;
    end
    hold = 1'b0;
    wait_rsp_drain();
  endtask

  task automatic run_entry(input int i);
    int    errs_before;
    string what;
    errs_before = err_cnt;
    what        = "command";
    case (tab_kind[i])
      K_NEXT: begin
        what = "dispatch";
        do_dispatch(i);
      end
      K_POST: begin
        start_hold();
        send_cmd(i);
        posted++;
      end
      K_DRAIN: begin
        what        = "burst";
        errs_before = burst_err_base;
        finish_burst();
      end
      default: begin
        send_cmd(i);
        wait_rsp_drain();
      end
    endcase
    if (tab_kind[i] != K_POST) begin
      tests++;
      if (err_cnt != errs_before) begin
        failed++;
      end
      $display("test %0d %s: %s", i, what, (err_cnt == errs_before) ? "ok" : "failed");
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    cmd_valid_i    = 1'b0;
    cmd_word_i     = '0;
    rsp_credit_i   = 1'b0;
    sched_next_i   = 1'b0;
    err_cnt        = 0;
    rng_state      = 32'd2126;
    hold           = 1'b0;
    cmd_credits    = CMD_DEPTH;
    hold_crd_seen  = 0;
    posted         = 0;
    burst_err_base = 0;
    next_wait      = 1'b0;
    got_next       = 1'b0;
    got_idle       = 1'b0;
    got_thr        = '0;
    tests          = 0;
    failed         = 0;
    cycle_cnt      = 0;
    build_table();
    timeout_limit = tab_kind.size() * (MAX_THREADS + 8);
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < tab_kind.size(); i++) begin
      run_entry(i);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests, failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
